// ==== Makefile ====
# Verilator build, run, lint and clean for the decode-to-execute stage

VERILATOR ?= verilator
TOP       ?= tb_decode_execute
RTL_TOP   ?= decode_execute
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR)

# the result is decided by the pass line in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/branch_resolver.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_resolver #(
  parameter int OPERAND_W  = 32,
  parameter int DELAY_SLOT = 1
) (
  input  wire [OPERAND_W-1:0]                pc_decode_i,
  input  isa_pkg::op_e                       decode_op_i,
  input  wire [isa_pkg::IMM16_W-1:0]         decode_imm16_i,
  input  wire [isa_pkg::IMMJBR_UPPER_W-1:0]  decode_immjbr_upper_i,
  input  wire                                predicted_flag_i,
  input  wire                                jr_ready_i,
  input  wire                                pipeline_flush_i,
  input  wire [OPERAND_W-1:0]                decode_rfb_i,
  input  wire [OPERAND_W-1:0]                execute_rfb_i,
  input  wire                                execute_bubble_i,
  input  isa_pkg::op_e                       execute_op_i,
  output logic                               decode_branch_o,
  output logic [OPERAND_W-1:0]               decode_branch_target_o,
  output logic                               except_align_o,
  output logic [OPERAND_W-1:0]               mispredict_target_o,
  output logic [OPERAND_W-1:0]               link_value_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // byte offset width, word offset plus two zero bits
  localparam int OFFS_W = IMMJBR_UPPER_W + IMM16_W + 2;

  logic [OPERAND_W-1:0] imm_offset;
  logic [OPERAND_W-1:0] imm_target;
  logic [OPERAND_W-1:0] reg_target;
  logic [OPERAND_W-1:0] next_pc;
  logic                 imm_taken;
  logic                 mispredicted_sense;
  branch_kind_e         kind;

  // sign-extend the 26-bit word offset and scale to bytes
  assign imm_offset = {{(OPERAND_W-OFFS_W){decode_immjbr_upper_i[IMMJBR_UPPER_W-1]}},
                       decode_immjbr_upper_i, decode_imm16_i, 2'b00};
  assign imm_target = pc_decode_i + imm_offset;

  // conditional branches only go early when the prediction says taken
  assign imm_taken = (decode_op_i == op_j) || (decode_op_i == op_jal) ||
                     ((decode_op_i == op_bf) && predicted_flag_i) ||
                     ((decode_op_i == op_bnf) && !predicted_flag_i);

  always_comb begin
    if (imm_taken) begin
      kind = bk_imm;
    end else if ((decode_op_i == op_jr) && jr_ready_i) begin
      kind = bk_reg;
    end else begin
      kind = bk_none;
    end
  end

  // when the writer was bubbled ahead, rb is only valid from the execute bypass
  assign reg_target = (execute_bubble_i || (execute_op_i == op_jr)) ?
                      execute_rfb_i : decode_rfb_i;

  assign decode_branch_o        = (kind != bk_none) && !pipeline_flush_i;
  assign decode_branch_target_o = (kind == bk_imm) ? imm_target : reg_target;

  assign except_align_o = decode_branch_o && (decode_branch_target_o[1:0] != 2'b00);

  // return point skips the delay slot when one exists
  assign next_pc = (DELAY_SLOT != 0) ? pc_decode_i + OPERAND_W'(8) :
                                       pc_decode_i + OPERAND_W'(4);

  assign link_value_o = next_pc;

  // a branch predicted not taken that turns out taken goes to the immediate target
  assign mispredicted_sense = ((decode_op_i == op_bf) && !predicted_flag_i) ||
                              ((decode_op_i == op_bnf) && predicted_flag_i);

  assign mispredict_target_o = mispredicted_sense ? imm_target : next_pc;

endmodule

`default_nettype wire

// ==== hdl/decode_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_execute #(
  parameter int OPERAND_W  = 32,
  parameter int DELAY_SLOT = 1
) (
  input  wire                                clk,
  input  wire                                rst,

  // pipeline control
  input  wire                                padv_i,
  input  wire                                pipeline_flush_i,

  // decode stage
  input  wire [OPERAND_W-1:0]                pc_decode_i,
  input  isa_pkg::op_e                       decode_op_i,
  input  wire                                decode_rf_wb_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]       decode_rfd_adr_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]       decode_rfa_adr_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]       decode_rfb_adr_i,
  input  wire [isa_pkg::IMM16_W-1:0]         decode_imm16_i,
  input  wire [isa_pkg::IMMJBR_UPPER_W-1:0]  decode_immjbr_upper_i,
  input  wire [OPERAND_W-1:0]                decode_immediate_i,
  input  wire                                decode_immediate_sel_i,
  input  wire                                predicted_flag_i,

  // register operands, rb read in decode and bypassed from execute
  input  wire [OPERAND_W-1:0]                decode_rfb_i,
  input  wire [OPERAND_W-1:0]                execute_rfb_i,

  // control stage
  input  isa_pkg::op_e                       ctrl_op_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]       ctrl_rfd_adr_i,

  // decode results
  output logic                               decode_branch_o,
  output logic [OPERAND_W-1:0]               decode_branch_target_o,
  output logic                               decode_bubble_o,
  output logic                               decode_valid_o,

  // execute stage
  output logic [OPERAND_W-1:0]               pc_execute_o,
  output isa_pkg::op_e                       execute_op_o,
  output logic                               execute_rf_wb_o,
  output logic [isa_pkg::RF_ADDR_W-1:0]      execute_rfd_adr_o,
  output logic [isa_pkg::IMM16_W-1:0]        execute_imm16_o,
  output logic [isa_pkg::IMMJBR_UPPER_W-1:0] execute_immjbr_upper_o,
  output logic [OPERAND_W-1:0]               execute_immediate_o,
  output logic                               execute_immediate_sel_o,
  output logic                               execute_predicted_flag_o,
  output logic [OPERAND_W-1:0]               execute_mispredict_target_o,
  output logic [OPERAND_W-1:0]               execute_jal_result_o,
  output logic                               execute_except_align_o,
  output logic                               execute_bubble_o
);

  logic                 jr_ready;
  logic                 except_align;
  logic [OPERAND_W-1:0] mispredict_target;
  logic [OPERAND_W-1:0] link_value;

  hazard_unit u_hazard (
    .clk               (clk),
    .rst               (rst),
    .padv_i            (padv_i),
    .decode_op_i       (decode_op_i),
    .decode_rfa_adr_i  (decode_rfa_adr_i),
    .decode_rfb_adr_i  (decode_rfb_adr_i),
    .execute_op_i      (execute_op_o),
    .execute_rfd_adr_i (execute_rfd_adr_o),
    .execute_rf_wb_i   (execute_rf_wb_o),
    .ctrl_op_i         (ctrl_op_i),
    .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
    .decode_bubble_o   (decode_bubble_o),
    .jr_ready_o        (jr_ready)
  );

  branch_resolver #(
    .OPERAND_W  (OPERAND_W),
    .DELAY_SLOT (DELAY_SLOT)
  ) u_branch (
    .pc_decode_i            (pc_decode_i),
    .decode_op_i            (decode_op_i),
    .decode_imm16_i         (decode_imm16_i),
    .decode_immjbr_upper_i  (decode_immjbr_upper_i),
    .predicted_flag_i       (predicted_flag_i),
    .jr_ready_i             (jr_ready),
    .pipeline_flush_i       (pipeline_flush_i),
    .decode_rfb_i           (decode_rfb_i),
    .execute_rfb_i          (execute_rfb_i),
    .execute_bubble_i       (execute_bubble_o),
    .execute_op_i           (execute_op_o),
    .decode_branch_o        (decode_branch_o),
    .decode_branch_target_o (decode_branch_target_o),
    .except_align_o         (except_align),
    .mispredict_target_o    (mispredict_target),
    .link_value_o           (link_value)
  );

  execute_regs #(
    .OPERAND_W (OPERAND_W)
  ) u_regs (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (padv_i),
    .pipeline_flush_i            (pipeline_flush_i),
    .decode_bubble_i             (decode_bubble_o),
    .pc_decode_i                 (pc_decode_i),
    .decode_op_i                 (decode_op_i),
    .decode_rf_wb_i              (decode_rf_wb_i),
    .decode_rfd_adr_i            (decode_rfd_adr_i),
    .decode_imm16_i              (decode_imm16_i),
    .decode_immjbr_upper_i       (decode_immjbr_upper_i),
    .decode_immediate_i          (decode_immediate_i),
    .decode_immediate_sel_i      (decode_immediate_sel_i),
    .predicted_flag_i            (predicted_flag_i),
    .except_align_i              (except_align),
    .mispredict_target_i         (mispredict_target),
    .link_value_i                (link_value),
    .pc_execute_o                (pc_execute_o),
    .execute_op_o                (execute_op_o),
    .execute_rf_wb_o             (execute_rf_wb_o),
    .execute_rfd_adr_o           (execute_rfd_adr_o),
    .execute_imm16_o             (execute_imm16_o),
    .execute_immjbr_upper_o      (execute_immjbr_upper_o),
    .execute_immediate_o         (execute_immediate_o),
    .execute_immediate_sel_o     (execute_immediate_sel_o),
    .execute_predicted_flag_o    (execute_predicted_flag_o),
    .execute_mispredict_target_o (execute_mispredict_target_o),
    .execute_jal_result_o        (execute_jal_result_o),
    .execute_except_align_o      (execute_except_align_o),
    .execute_bubble_o            (execute_bubble_o),
    .decode_valid_o              (decode_valid_o)
  );

endmodule

`default_nettype wire

// ==== hdl/execute_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_regs #(
  parameter int OPERAND_W = 32
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                padv_i,
  input  wire                                pipeline_flush_i,
  input  wire                                decode_bubble_i,
  input  wire [OPERAND_W-1:0]                pc_decode_i,
  input  isa_pkg::op_e                       decode_op_i,
  input  wire                                decode_rf_wb_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]       decode_rfd_adr_i,
  input  wire [isa_pkg::IMM16_W-1:0]         decode_imm16_i,
  input  wire [isa_pkg::IMMJBR_UPPER_W-1:0]  decode_immjbr_upper_i,
  input  wire [OPERAND_W-1:0]                decode_immediate_i,
  input  wire                                decode_immediate_sel_i,
  input  wire                                predicted_flag_i,
  input  wire                                except_align_i,
  input  wire [OPERAND_W-1:0]                mispredict_target_i,
  input  wire [OPERAND_W-1:0]                link_value_i,
  output logic [OPERAND_W-1:0]               pc_execute_o,
  output isa_pkg::op_e                       execute_op_o,
  output logic                               execute_rf_wb_o,
  output logic [isa_pkg::RF_ADDR_W-1:0]      execute_rfd_adr_o,
  output logic [isa_pkg::IMM16_W-1:0]        execute_imm16_o,
  output logic [isa_pkg::IMMJBR_UPPER_W-1:0] execute_immjbr_upper_o,
  output logic [OPERAND_W-1:0]               execute_immediate_o,
  output logic                               execute_immediate_sel_o,
  output logic                               execute_predicted_flag_o,
  output logic [OPERAND_W-1:0]               execute_mispredict_target_o,
  output logic [OPERAND_W-1:0]               execute_jal_result_o,
  output logic                               execute_except_align_o,
  output logic                               execute_bubble_o,
  output logic                               decode_valid_o
);

  import isa_pkg::*;

  logic is_cond_branch;

  assign is_cond_branch = (decode_op_i == op_bf) || (decode_op_i == op_bnf);

  // flush beats advance for the op field
  always_ff @(posedge clk) begin
    if (rst) begin
      execute_op_o <= NOP_OP;
    end else if (pipeline_flush_i) begin
      execute_op_o <= NOP_OP;
    end else if (padv_i) begin
      // rfe has to reach control to redirect fetch, so it survives its own bubble
      if (decode_bubble_i && (decode_op_i != op_rfe)) begin
        execute_op_o <= NOP_OP;
      end else begin
        execute_op_o <= decode_op_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_rf_wb_o  <= 1'b0;
      execute_bubble_o <= 1'b0;
    end else if (pipeline_flush_i) begin
      execute_rf_wb_o  <= 1'b0;
      execute_bubble_o <= 1'b0;
    end else if (padv_i) begin
      execute_rf_wb_o  <= decode_rf_wb_i && !decode_bubble_i;
      execute_bubble_o <= decode_bubble_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_except_align_o <= 1'b0;
    end else if (padv_i) begin
      execute_except_align_o <= except_align_i;
    end
  end

  // valid follows the advance strobe by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_valid_o <= 1'b0;
    end else begin
      decode_valid_o <= padv_i;
    end
  end

  // payload registers load on every advance
  always_ff @(posedge clk) begin
    if (padv_i) begin
      pc_execute_o            <= pc_decode_i;
      execute_rfd_adr_o       <= decode_rfd_adr_i;
      execute_imm16_o         <= decode_imm16_i;
      execute_immjbr_upper_o  <= decode_immjbr_upper_i;
      execute_immediate_o     <= decode_immediate_i;
      execute_immediate_sel_o <= decode_immediate_sel_i;
      execute_jal_result_o    <= link_value_i;
    end
  end

  // prediction state is only meaningful for conditional branches
  always_ff @(posedge clk) begin
    if (padv_i && is_cond_branch) begin
      execute_mispredict_target_o <= mispredict_target_i;
      execute_predicted_flag_o    <= predicted_flag_i;
    end
  end

  // a bubbled slot must never write the register file
  bubble_is_nop: assert property (
    @(posedge clk) disable iff (rst)
    (padv_i && decode_bubble_i && (decode_op_i != op_rfe))
      |=> ((execute_op_o == NOP_OP) && !execute_rf_wb_o)
  ) else $error("bubbled advance left a live op in execute");

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           padv_i,
  input  isa_pkg::op_e                  decode_op_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]  decode_rfa_adr_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]  decode_rfb_adr_i,
  input  isa_pkg::op_e                  execute_op_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]  execute_rfd_adr_i,
  input  wire                           execute_rf_wb_i,
  input  isa_pkg::op_e                  ctrl_op_i,
  input  wire [isa_pkg::RF_ADDR_W-1:0]  ctrl_rfd_adr_i,
  output logic                          decode_bubble_o,
  output logic                          jr_ready_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic          execute_late_result;
  logic          ctrl_late_result;
  logic          execute_src_match;
  logic          ctrl_src_match;
  logic          ctrl_interlock;
  logic          execute_writes_rb;
  bubble_cause_e cause;

  // loads and mfspr deliver their result one stage late, so bypass cannot help
  assign execute_late_result = (execute_op_i == op_load) || (execute_op_i == op_mfspr);
  assign ctrl_late_result    = (ctrl_op_i == op_load) || (ctrl_op_i == op_mfspr);

  assign execute_src_match = (decode_rfa_adr_i == execute_rfd_adr_i) ||
                             (decode_rfb_adr_i == execute_rfd_adr_i);
  assign ctrl_src_match    = (decode_rfa_adr_i == ctrl_rfd_adr_i) ||
                             (decode_rfb_adr_i == ctrl_rfd_adr_i);

  assign ctrl_interlock = ctrl_late_result && ctrl_src_match;

  // jr reads rb in decode where a pending write to it is not yet visible
  assign execute_writes_rb = execute_rf_wb_i && (decode_rfb_adr_i == execute_rfd_adr_i);

  assign jr_ready_o = !(ctrl_interlock || execute_writes_rb);

  // rfe always stalls regardless of operands so it is checked first
  always_comb begin
    if (decode_op_i == op_rfe) begin
      cause = bc_rfe;
    end else if (execute_late_result && execute_src_match) begin
      cause = bc_load_use;
    end else if ((decode_op_i == op_jr) && !jr_ready_o) begin
      cause = bc_jr_wait;
    end else begin
      cause = bc_none;
    end
  end

  assign decode_bubble_o = (cause != bc_none) && padv_i;

  // a data hazard bubble empties execute so the stall it caused cannot repeat there
  bubble_drains_execute: assert property (
    @(posedge clk) disable iff (rst)
    (decode_bubble_o && (cause != bc_rfe)) |=> !(execute_late_result || execute_rf_wb_i)
  ) else $error("bubble left a register writer in execute");

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // register file address width
  localparam int RF_ADDR_W = 5;

  // low immediate field of the instruction word
  localparam int IMM16_W = 16;

  // upper jump/branch immediate field
  // together with the low field it makes a 26-bit word offset
  localparam int IMMJBR_UPPER_W = 10;

  // instruction classes seen by the decode-to-execute stage
  typedef enum logic [3:0] {
    // no operation, also what a bubble turns into
    op_nop,
    // register or immediate arithmetic and logic
    op_alu,
    // loads produce their result in control
    op_load,
    op_store,
    // special purpose register read, result also late
    op_mfspr,
    op_mtspr,
    // jump to immediate target
    op_j,
    // jump and link, writes the return address
    op_jal,
    // conditional branch if flag set
    op_bf,
    // conditional branch if flag clear
    op_bnf,
    // jump to register
    op_jr,
    // return from exception, resolved in control
    op_rfe
  } op_e;

  // op that execute holds after reset, flush or bubble
  localparam op_e NOP_OP = op_nop;

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // why decode inserts a bubble into execute
  typedef enum logic [1:0] {
    // decode may advance normally
    bc_none,
    // load or mfspr in execute writes a register that decode reads
    bc_load_use,
    // jump register operand still in flight
    bc_jr_wait,
    // rfe must drain to control before fetch continues
    bc_rfe
  } bubble_cause_e;

  // which kind of branch decode resolves this cycle
  typedef enum logic [1:0] {
    // no branch taken
    bk_none,
    // immediate target, pc relative
    bk_imm,
    // target taken from a register operand
    bk_reg
  } branch_kind_e;

endpackage

`default_nettype wire

// ==== test/tb_decode_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_decode_execute;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int OPERAND_W       = 32;
  localparam int DELAY_SLOT      = 1;
  localparam int CYCLES_PER_TEST = 200;
  localparam int NUM_TESTS       = 6;
  // reset and all test cycles at 8 ns each, plus slack
  localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + 10) * 8 + 400;

  logic        clk;
  logic        rst;
  logic        padv;
  logic        flush;
  logic [31:0] pc_decode;
  op_e         decode_op;
  logic        decode_rf_wb;
  logic [4:0]  rfd_adr;
  logic [4:0]  rfa_adr;
  logic [4:0]  rfb_adr;
  logic [15:0] imm16;
  logic [9:0]  immjbr_upper;
  logic [31:0] immediate;
  logic        immediate_sel;
  logic        predicted_flag;
  logic [31:0] decode_rfb;
  logic [31:0] execute_rfb;
  op_e         ctrl_op;
  logic [4:0]  ctrl_rfd_adr;

  logic        branch;
  logic [31:0] branch_target;
  logic        bubble;
  logic        valid;
  logic [31:0] pc_execute;
  op_e         execute_op;
  logic        execute_rf_wb;
  logic [4:0]  execute_rfd_adr;
  logic [15:0] execute_imm16;
  logic [9:0]  execute_upper;
  logic [31:0] execute_immediate;
  logic        execute_immediate_sel;
  logic        execute_pflag;
  logic [31:0] execute_mis_target;
  logic [31:0] execute_jal;
  logic        execute_align;
  logic        execute_bubble;

  // reference copy of the execute stage
  op_e         m_op;
  logic        m_rf_wb;
  logic        m_bubble;
  logic        m_valid;
  logic        m_align;
  logic [4:0]  m_rfd;
  logic [31:0] m_pc;
  logic [15:0] m_imm16;
  logic [9:0]  m_upper;
  logic [31:0] m_immediate;
  logic        m_imm_sel;
  logic [31:0] m_jal;
  logic [31:0] m_mis;
  logic        m_pflag;
  logic        m_mis_valid;

  int seed;
  int errors;
  int checks;
  int tests_run;

  decode_execute #(
    .OPERAND_W  (OPERAND_W),
    .DELAY_SLOT (DELAY_SLOT)
  ) dut (
    .clk                         (clk),
    .rst                         (rst),
    .padv_i                      (padv),
    .pipeline_flush_i            (flush),
    .pc_decode_i                 (pc_decode),
    .decode_op_i                 (decode_op),
    .decode_rf_wb_i              (decode_rf_wb),
    .decode_rfd_adr_i            (rfd_adr),
    .decode_rfa_adr_i            (rfa_adr),
    .decode_rfb_adr_i            (rfb_adr),
    .decode_imm16_i              (imm16),
    .decode_immjbr_upper_i       (immjbr_upper),
    .decode_immediate_i          (immediate),
    .decode_immediate_sel_i      (immediate_sel),
    .predicted_flag_i            (predicted_flag),
    .decode_rfb_i                (decode_rfb),
    .execute_rfb_i               (execute_rfb),
    .ctrl_op_i                   (ctrl_op),
    .ctrl_rfd_adr_i              (ctrl_rfd_adr),
    .decode_branch_o             (branch),
    .decode_branch_target_o      (branch_target),
    .decode_bubble_o             (bubble),
    .decode_valid_o              (valid),
    .pc_execute_o                (pc_execute),
    .execute_op_o                (execute_op),
    .execute_rf_wb_o             (execute_rf_wb),
    .execute_rfd_adr_o           (execute_rfd_adr),
    .execute_imm16_o             (execute_imm16),
    .execute_immjbr_upper_o      (execute_upper),
    .execute_immediate_o         (execute_immediate),
    .execute_immediate_sel_o     (execute_immediate_sel),
    .execute_predicted_flag_o    (execute_pflag),
    .execute_mispredict_target_o (execute_mis_target),
    .execute_jal_result_o        (execute_jal),
    .execute_except_align_o      (execute_align),
    .execute_bubble_o            (execute_bubble)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // each test draws its ops from a small set that exercises one behavior
  function automatic op_e pick_op(input int mode, input logic [3:0] sel);
    op_e op;
    case (mode)
      1: op = sel[1] ? (sel[0] ? op_mtspr : op_store) : (sel[0] ? op_alu : op_nop);
      3: op = sel[1] ? (sel[0] ? op_alu : op_rfe) : (sel[0] ? op_mfspr : op_load);
      4: op = sel[1] ? (sel[0] ? op_bnf : op_bf) : (sel[0] ? op_jal : op_j);
      5: op = sel[1] ? (sel[0] ? op_alu : op_load) : op_jr;
      6: op = sel[1] ? (sel[0] ? op_bf : op_jal) : (sel[0] ? op_j : op_jr);
      default: op = (sel < 4'd12) ? op_e'(sel) : op_alu;
    endcase
    return op;
  endfunction

  task automatic drive_inputs(input int mode);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic        narrow;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    // few register addresses so that sources and destinations collide often
    narrow = (mode == 3) || (mode == 5);
    padv = (mode == 1) ? r0[0] : (r0[2:0] != 3'd0);
    flush = (mode == 2) && (r0[4:3] == 2'd0);
    decode_op = pick_op(mode, r0[8:5]);
    decode_rf_wb = r0[9];
    predicted_flag = r0[10];
    immediate_sel = r0[11];
    rfa_adr = narrow ? {3'd0, r1[1:0]} : r1[4:0];
    rfb_adr = narrow ? {3'd0, r1[6:5]} : r1[9:5];
    rfd_adr = narrow ? {3'd0, r1[11:10]} : r1[14:10];
    ctrl_rfd_adr = narrow ? {3'd0, r1[16:15]} : r1[19:15];
    ctrl_op = narrow ? (r1[20] ? (r1[21] ? op_mfspr : op_load) : op_alu) : op_nop;
    // only the alignment test uses targets with nonzero low bits
    pc_decode = (mode == 6) ? r2 : {r2[31:2], 2'b00};
    decode_rfb = (mode == 6) ? r3 : {r3[31:2], 2'b00};
    execute_rfb = (mode == 6) ? {r3[15:0], r3[31:16]} : {r3[15:0], r3[31:18], 2'b00};
    imm16 = r4[15:0];
    immjbr_upper = r4[25:16];
    immediate = r4 ^ r2;
  endtask

  task automatic check_execute();
    compare_value("execute_op_o", 32'(execute_op), 32'(m_op));
    compare_value("execute_rf_wb_o", 32'(execute_rf_wb), 32'(m_rf_wb));
    compare_value("execute_bubble_o", 32'(execute_bubble), 32'(m_bubble));
    compare_value("decode_valid_o", 32'(valid), 32'(m_valid));
    compare_value("execute_except_align_o", 32'(execute_align), 32'(m_align));
    compare_value("execute_rfd_adr_o", 32'(execute_rfd_adr), 32'(m_rfd));
    compare_value("pc_execute_o", pc_execute, m_pc);
    compare_value("execute_imm16_o", 32'(execute_imm16), 32'(m_imm16));
    compare_value("execute_immjbr_upper_o", 32'(execute_upper), 32'(m_upper));
    compare_value("execute_immediate_o", execute_immediate, m_immediate);
    compare_value("execute_immediate_sel_o", 32'(execute_immediate_sel), 32'(m_imm_sel));
    compare_value("execute_jal_result_o", execute_jal, m_jal);
    if (m_mis_valid) begin
      compare_value("execute_mispredict_target_o", execute_mis_target, m_mis);
      compare_value("execute_predicted_flag_o", 32'(execute_pflag), 32'(m_pflag));
    end
  endtask

  task automatic run_cycle(input int mode);
    bubble_cause_e cause;
    logic          late_exec;
    logic          ctrl_lock;
    logic          jr_ok;
    logic          imm_take;
    logic          cond_branch;
    logic          disagree;
    logic          exp_bubble;
    logic          exp_branch;
    logic          exp_align;
    logic [25:0]   word_off;
    logic [31:0]   imm_tgt;
    logic [31:0]   reg_tgt;
    logic [31:0]   exp_target;
    logic [31:0]   next_pc;
    drive_inputs(mode);
    #2;
    late_exec = (m_op == op_load) || (m_op == op_mfspr);
    ctrl_lock = ((ctrl_op == op_load) || (ctrl_op == op_mfspr)) &&
                ((rfa_adr == ctrl_rfd_adr) || (rfb_adr == ctrl_rfd_adr));
    jr_ok = !ctrl_lock && !(m_rf_wb && (rfb_adr == m_rfd));
    if (decode_op == op_rfe) begin
      cause = bc_rfe;
    end else if (late_exec && ((rfa_adr == m_rfd) || (rfb_adr == m_rfd))) begin
      cause = bc_load_use;
    end else if ((decode_op == op_jr) && !jr_ok) begin
      cause = bc_jr_wait;
    end else begin
      cause = bc_none;
    end
    exp_bubble = padv && (cause != bc_none);
    // word offset, sign extended and scaled to bytes
    word_off = {immjbr_upper, imm16};
    imm_tgt = pc_decode + {{4{word_off[25]}}, word_off, 2'b00};
    next_pc = pc_decode + ((DELAY_SLOT != 0) ? 32'd8 : 32'd4);
    imm_take = (decode_op == op_j) || (decode_op == op_jal) ||
               ((decode_op == op_bf) && predicted_flag) ||
               ((decode_op == op_bnf) && !predicted_flag);
    reg_tgt = (m_bubble || (m_op == op_jr)) ? execute_rfb : decode_rfb;
    exp_branch = (imm_take || ((decode_op == op_jr) && jr_ok)) && !flush;
    exp_target = imm_take ? imm_tgt : reg_tgt;
    exp_align = exp_branch && (exp_target[1:0] != 2'b00);
    cond_branch = (decode_op == op_bf) || (decode_op == op_bnf);
    disagree = ((decode_op == op_bf) && !predicted_flag) ||
               ((decode_op == op_bnf) && predicted_flag);
    compare_value("decode_bubble_o", 32'(bubble), 32'(exp_bubble));
    compare_value("decode_branch_o", 32'(branch), 32'(exp_branch));
    if (exp_branch) begin
      compare_value("decode_branch_target_o", branch_target, exp_target);
    end
    // what the coming edge should load
    if (padv) begin
      m_pc = pc_decode;
      m_rfd = rfd_adr;
      m_imm16 = imm16;
      m_upper = immjbr_upper;
      m_immediate = immediate;
      m_imm_sel = immediate_sel;
      m_jal = next_pc;
      m_align = exp_align;
      if (cond_branch) begin
        m_mis = disagree ? imm_tgt : next_pc;
        m_pflag = predicted_flag;
        m_mis_valid = 1'b1;
      end
    end
    if (flush) begin
      m_op = op_nop;
      m_rf_wb = 1'b0;
      m_bubble = 1'b0;
    end else if (padv) begin
      m_op = (exp_bubble && (decode_op != op_rfe)) ? op_nop : decode_op;
      m_rf_wb = decode_rf_wb && !exp_bubble;
      m_bubble = exp_bubble;
    end
    m_valid = padv;
    @(posedge clk);
    #1;
    check_execute();
  endtask

  task automatic run_test(input string name, input int mode);
    int errors_before;
    errors_before = errors;
    repeat (CYCLES_PER_TEST) begin
      run_cycle(mode);
    end
    tests_run++;
    $display("test %-16s %0d cycles, %0d errors, %s", name, CYCLES_PER_TEST,
             errors - errors_before, (errors == errors_before) ? "ok" : "with errors");
  endtask

  initial begin
    seed = 80489;
    errors = 0;
    checks = 0;
    tests_run = 0;
    rst = 1'b1;
    // advance during reset so that the unreset payload registers hold known values
    padv = 1'b1;
    flush = 1'b0;
    pc_decode = 32'h0000_0100;
    decode_op = op_nop;
    decode_rf_wb = 1'b0;
    rfd_adr = 5'd0;
    rfa_adr = 5'd0;
    rfb_adr = 5'd0;
    imm16 = 16'd0;
    immjbr_upper = 10'd0;
    immediate = 32'd0;
    immediate_sel = 1'b0;
    predicted_flag = 1'b0;
    decode_rfb = 32'd0;
    execute_rfb = 32'd0;
    ctrl_op = op_nop;
    ctrl_rfd_adr = 5'd0;
    m_op = op_nop;
    m_rf_wb = 1'b0;
    m_bubble = 1'b0;
    m_valid = 1'b0;
    m_align = 1'b0;
    m_mis_valid = 1'b0;
    m_mis = 32'd0;
    m_pflag = 1'b0;
    m_pc = pc_decode;
    m_rfd = rfd_adr;
    m_imm16 = imm16;
    m_upper = immjbr_upper;
    m_immediate = immediate;
    m_imm_sel = immediate_sel;
    m_jal = pc_decode + ((DELAY_SLOT != 0) ? 32'd8 : 32'd4);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    run_test("advance_hold", 1);
    run_test("flush", 2);
    run_test("load_use_rfe", 3);
    run_test("imm_branch", 4);
    run_test("jump_register", 5);
    run_test("align_exception", 6);
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/hazard_unit.sv
hdl/branch_resolver.sv
hdl/execute_regs.sv
hdl/decode_execute.sv
test/tb_decode_execute.sv
